// File: logic/rv_exec_pkg.sv
package rv_exec_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [6:0]  opcode_t;

  // rv32i base opcodes handled by the execute unit
  localparam opcode_t opc_lui    = 7'b0110111;
  localparam opcode_t opc_auipc  = 7'b0010111;
  localparam opcode_t opc_jal    = 7'b1101111;
  localparam opcode_t opc_jalr   = 7'b1100111;
  localparam opcode_t opc_branch = 7'b1100011;
  localparam opcode_t opc_op_imm = 7'b0010011;
  localparam opcode_t opc_op     = 7'b0110011;

  // funct3 for op and op_imm
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_srl  = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // funct3 for branches, 2 and 3 are reserved
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  localparam logic [6:0] f7_base = 7'b0000000;
  // selects sub and sra
  localparam logic [6:0] f7_alt  = 7'b0100000;

  localparam word_t insn_len = 32'd4;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    opcode_t    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    opcode_t     opcode;
  } i_fmt_t;

  // branch offset bits are scattered around rs1/rs2
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    opcode_t    opcode;
  } b_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    b_fmt_t b;
  } insn_word_u;

endpackage

// File: logic/int_alu.sv
`timescale 1ns/1ps

module int_alu import rv_exec_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       in_valid,
  input  insn_word_u insn,
  input  word_t      pc,
  input  word_t      rs1_data,
  input  word_t      rs2_data,
  output logic       alu_valid,
  output reg_idx_t   alu_rd,
  output word_t      alu_data,
  output logic       alu_writes,
  output logic       alu_illegal
);

  word_t      imm_i;
  word_t      imm_u;
  word_t      operand_b;
  logic [4:0] shamt;
  logic       is_op;
  logic       f7_is_alt;
  logic       funct_ok;
  word_t      arith_res;
  word_t      result;
  logic       writes;
  logic       illegal;

  // operand selection and funct legality
  always_comb begin
    imm_i     = {{20{insn.i.imm12[11]}}, insn.i.imm12};
    imm_u     = {insn[31:12], 12'b0};
    is_op     = (insn.r.opcode == opc_op);
    operand_b = is_op ? rs2_data : imm_i;
    // shamt sits in the rs2 field for the immediate shifts too
    shamt     = operand_b[4:0];
    f7_is_alt = (insn.r.funct7 == f7_alt);

    if (is_op) begin
      funct_ok = (insn.r.funct7 == f7_base) ||
                 (f7_is_alt && (insn.r.funct3 == f3_add || insn.r.funct3 == f3_srl));
    end else if (insn.r.funct3 == f3_sll) begin
      funct_ok = (insn.r.funct7 == f7_base);
    end else if (insn.r.funct3 == f3_srl) begin
      funct_ok = (insn.r.funct7 == f7_base) || f7_is_alt;
    end else begin
      funct_ok = 1'b1;
    end
  end

  always_comb begin
    case (insn.r.funct3)
      f3_add:  arith_res = (is_op && f7_is_alt) ? rs1_data - operand_b : rs1_data + operand_b;
      f3_sll:  arith_res = rs1_data << shamt;
      f3_slt:  arith_res = {31'b0, $signed(rs1_data) < $signed(operand_b)};
      f3_sltu: arith_res = {31'b0, rs1_data < operand_b};
      f3_xor:  arith_res = rs1_data ^ operand_b;
      f3_srl:  arith_res = f7_is_alt ? word_t'($signed(rs1_data) >>> shamt) : rs1_data >> shamt;
      f3_or:   arith_res = rs1_data | operand_b;
      default: arith_res = rs1_data & operand_b;
    endcase
  end

  // per-opcode result, write intent and legality
  always_comb begin
    result  = '0;
    writes  = 1'b0;
    illegal = 1'b0;
    case (insn.r.opcode)
      opc_lui: begin
        result = imm_u;
        writes = 1'b1;
      end
      opc_auipc: begin
        result = pc + imm_u;
        writes = 1'b1;
      end
      opc_jal, opc_jalr: begin
        result = pc + insn_len;
        writes = 1'b1;
      end
      opc_op, opc_op_imm: begin
        result  = arith_res;
        writes  = 1'b1;
        illegal = !funct_ok;
      end
      opc_branch: begin
        result = '0;
      end
      default: illegal = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      alu_valid   <= 1'b0;
      alu_writes  <= 1'b0;
      alu_illegal <= 1'b0;
    end else begin
      alu_valid   <= in_valid;
      alu_writes  <= in_valid && writes;
      alu_illegal <= in_valid && illegal;
    end
  end

  always_ff @(posedge clk) begin
    alu_rd   <= insn.r.rd;
    alu_data <= result;
  end

endmodule

// File: logic/branch_unit.sv
`timescale 1ns/1ps

module branch_unit import rv_exec_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       in_valid,
  input  insn_word_u insn,
  input  word_t      pc,
  input  word_t      rs1_data,
  input  word_t      rs2_data,
  output logic       br_taken,
  output word_t      br_target,
  output logic       br_illegal
);

  word_t imm_b;
  word_t imm_j;
  word_t imm_i;
  logic  ops_eq;
  logic  ops_lt;
  logic  ops_ltu;
  logic  cond;
  logic  bad_f3;
  logic  taken;
  word_t target;

  always_comb begin
    imm_b = {{20{insn.b.imm12}}, insn.b.imm11, insn.b.imm10_5, insn.b.imm4_1, 1'b0};
    // no j view in the union, the jal offset is taken from the raw word
    imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
    imm_i = {{20{insn.i.imm12[11]}}, insn.i.imm12};

    ops_eq  = (rs1_data == rs2_data);
    ops_lt  = ($signed(rs1_data) < $signed(rs2_data));
    ops_ltu = (rs1_data < rs2_data);
  end

  // compare select
  always_comb begin
    cond   = 1'b0;
    bad_f3 = 1'b0;
    case (insn.b.funct3)
      f3_beq:  cond = ops_eq;
      f3_bne:  cond = !ops_eq;
      f3_blt:  cond = ops_lt;
      f3_bge:  cond = !ops_lt;
      f3_bltu: cond = ops_ltu;
      f3_bgeu: cond = !ops_ltu;
      default: bad_f3 = 1'b1;
    endcase
  end

  always_comb begin
    taken  = 1'b0;
    target = pc + imm_b;
    case (insn.b.opcode)
      opc_branch: taken = cond && !bad_f3;
      opc_jal: begin
        taken  = 1'b1;
        target = pc + imm_j;
      end
      opc_jalr: begin
        taken  = 1'b1;
        target = (rs1_data + imm_i) & ~word_t'(1);
      end
      default: taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      br_taken   <= 1'b0;
      br_illegal <= 1'b0;
    end else begin
      br_taken   <= in_valid && taken;
      br_illegal <= in_valid && (insn.b.opcode == opc_branch) && bad_f3;
    end
  end

  always_ff @(posedge clk) begin
    br_target <= target;
  end

endmodule

// File: logic/commit_stage.sv
`timescale 1ns/1ps

module commit_stage import rv_exec_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     alu_valid,
  input  reg_idx_t alu_rd,
  input  word_t    alu_data,
  input  logic     alu_writes,
  input  logic     alu_illegal,
  input  logic     br_taken,
  input  word_t    br_target,
  input  logic     br_illegal,
  output logic     res_valid,
  output reg_idx_t rd,
  output word_t    rd_data,
  output logic     rd_we,
  output logic     redirect,
  output word_t    redirect_pc,
  output logic     illegal
);

  logic any_illegal;
  logic write_ok;

  always_comb begin
    any_illegal = alu_illegal || br_illegal;
    // x0 writes are dropped here
    write_ok    = alu_writes && !any_illegal && (alu_rd != '0);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
      rd_we     <= 1'b0;
      redirect  <= 1'b0;
      illegal   <= 1'b0;
    end else begin
      res_valid <= alu_valid;
      rd_we     <= alu_valid && write_ok;
      redirect  <= alu_valid && br_taken && !any_illegal;
      illegal   <= alu_valid && any_illegal;
    end
  end

  // result payload, held between instructions
  always_ff @(posedge clk) begin
    if (alu_valid) begin
      rd          <= alu_rd;
      rd_data     <= alu_data;
      redirect_pc <= br_target;
    end
  end

endmodule

// File: logic/exec_stage.sv
`timescale 1ns/1ps

module exec_stage import rv_exec_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       in_valid,
  input  insn_word_u insn,
  input  word_t      pc,
  input  word_t      rs1_data,
  input  word_t      rs2_data,
  output logic       res_valid,
  output reg_idx_t   rd,
  output word_t      rd_data,
  output logic       rd_we,
  output logic       redirect,
  output word_t      redirect_pc,
  output logic       illegal
);

  logic     alu_valid;
  reg_idx_t alu_rd;
  word_t    alu_data;
  logic     alu_writes;
  logic     alu_illegal;
  logic     br_taken;
  word_t    br_target;
  logic     br_illegal;

  // both units see the same instruction on the same edge
  int_alu int_alu_inst (
    .clk(clk), .rst(rst), .in_valid(in_valid), .insn(insn), .pc(pc),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .alu_valid(alu_valid), .alu_rd(alu_rd), .alu_data(alu_data),
    .alu_writes(alu_writes), .alu_illegal(alu_illegal)
  );

  branch_unit branch_unit_inst (
    .clk(clk), .rst(rst), .in_valid(in_valid), .insn(insn), .pc(pc),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .br_taken(br_taken), .br_target(br_target), .br_illegal(br_illegal)
  );

  commit_stage commit_stage_inst (
    .clk(clk), .rst(rst), .alu_valid(alu_valid), .alu_rd(alu_rd), .alu_data(alu_data),
    .alu_writes(alu_writes), .alu_illegal(alu_illegal),
    .br_taken(br_taken), .br_target(br_target), .br_illegal(br_illegal),
    .res_valid(res_valid), .rd(rd), .rd_data(rd_data), .rd_we(rd_we),
    .redirect(redirect), .redirect_pc(redirect_pc), .illegal(illegal)
  );

endmodule

// File: testbench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
  output logic clk,
  output logic rst
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // rst drops after the third rising edge
  initial begin
    rst <= 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// File: testbench/exec_stage_props.sv
`timescale 1ns/1ps

module exec_stage_props (
  input logic clk,
  input logic rst,
  input logic in_valid,
  input logic res_valid,
  input logic rd_we,
  input logic redirect,
  input logic illegal
);

  // two register levels between strobe and result
  assert property (@(posedge clk) disable iff (rst) res_valid == $past(in_valid, 2))
    else $error("res_valid does not follow in_valid by two cycles");

  assert property (@(posedge clk) disable iff (rst) rd_we |-> res_valid)
    else $error("rd_we high without res_valid");

  assert property (@(posedge clk) disable iff (rst) redirect |-> res_valid)
    else $error("redirect high without res_valid");

  // an illegal instruction neither writes nor redirects
  assert property (@(posedge clk) disable iff (rst) illegal |-> !rd_we && !redirect)
    else $error("illegal instruction with a write or redirect");

endmodule

bind exec_stage exec_stage_props exec_stage_props_inst (
  .clk(clk), .rst(rst), .in_valid(in_valid), .res_valid(res_valid),
  .rd_we(rd_we), .redirect(redirect), .illegal(illegal)
);

// File: testbench/tb_exec_stage.sv
`timescale 1ns/1ps

module tb_exec_stage import rv_exec_pkg::*; ();

  typedef struct packed {
    word_t insn;
    logic  wr;
    word_t data;
    logic  we;
    logic  redir;
    word_t tgt;
    logic  ill;
  } expect_t;

  logic       clk;
  logic       rst;
  logic       in_valid;
  insn_word_u insn;
  word_t      pc;
  word_t      rs1_data;
  word_t      rs2_data;
  logic       res_valid;
  reg_idx_t   rd;
  word_t      rd_data;
  logic       rd_we;
  logic       redirect;
  word_t      redirect_pc;
  logic       illegal;

  int      check_errors;
  int      timeout_errors;
  expect_t exp_q[$];

  clock_gen clock_gen_inst (.clk(clk), .rst(rst));

  exec_stage exec_stage_inst (
    .clk(clk), .rst(rst), .in_valid(in_valid), .insn(insn), .pc(pc),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .res_valid(res_valid), .rd(rd),
    .rd_data(rd_data), .rd_we(rd_we), .redirect(redirect), .redirect_pc(redirect_pc),
    .illegal(illegal)
  );

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      check_errors++;
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
    if (act !== exp) begin
      check_errors++;
      $display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      check_errors++;
      $display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3, reg_idx_t rd_i, opcode_t opc);
    return {f7, rs2, rs1, f3, rd_i, opc};
  endfunction

  function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                  reg_idx_t rd_i, opcode_t opc);
    return {imm, rs1, f3, rd_i, opc};
  endfunction

  // byte offsets, bit 0 is not encoded
  function automatic word_t enc_b(logic [12:0] off, logic [2:0] f3);
    return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], opc_branch};
  endfunction

  function automatic word_t enc_j(logic [20:0] off, reg_idx_t rd_i);
    return {off[20], off[10:1], off[11], off[19:12], rd_i, opc_jal};
  endfunction

  // reference result straight from the rv32i rules
  task automatic predict(input word_t w, input word_t p, input word_t a, input word_t b);
    expect_t    e;
    opcode_t    opc;
    logic [2:0] f3;
    logic       base;
    logic       alt;
    word_t      imm_i;
    word_t      opb;
    logic       taken;
    opc    = w[6:0];
    f3     = w[14:12];
    base   = (w[31:25] == 7'h00);
    alt    = (w[31:25] == 7'h20);
    imm_i  = {{20{w[31]}}, w[31:20]};
    opb    = (opc == opc_op) ? b : imm_i;
    taken  = 1'b0;
    e      = '0;
    e.insn = w;
    case (opc)
      opc_op, opc_op_imm: begin
        e.wr = 1'b1;
        case (f3)
          3'd0: e.data = (opc == opc_op && alt) ? a - opb : a + opb;
          3'd1: e.data = a << opb[4:0];
          3'd2: e.data = ($signed(a) < $signed(opb)) ? 32'd1 : 32'd0;
          3'd3: e.data = (a < opb) ? 32'd1 : 32'd0;
          3'd4: e.data = a ^ opb;
          3'd5: e.data = alt ? word_t'($signed(a) >>> opb[4:0]) : a >> opb[4:0];
          3'd6: e.data = a | opb;
          default: e.data = a & opb;
        endcase
        if (opc == opc_op)
          e.ill = !(base || (alt && (f3 == 3'd0 || f3 == 3'd5)));
        else if (f3 == 3'd1 || f3 == 3'd5)
          e.ill = !(base || (alt && f3 == 3'd5));
      end
      opc_lui: begin
        e.wr   = 1'b1;
        e.data = {w[31:12], 12'h000};
      end
      opc_auipc: begin
        e.wr   = 1'b1;
        e.data = p + {w[31:12], 12'h000};
      end
      opc_jal, opc_jalr: begin
        e.wr   = 1'b1;
        e.data = p + 32'd4;
        taken  = 1'b1;
        if (opc == opc_jal)
          e.tgt = p + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        else
          e.tgt = (a + imm_i) & 32'hffff_fffe;
      end
      opc_branch: begin
        e.tgt = p + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        case (f3)
          3'd0: taken = (a == b);
          3'd1: taken = (a != b);
          3'd4: taken = ($signed(a) < $signed(b));
          3'd5: taken = ($signed(a) >= $signed(b));
          3'd6: taken = (a < b);
          3'd7: taken = (a >= b);
          default: e.ill = 1'b1;
        endcase
      end
      default: e.ill = 1'b1;
    endcase
    e.redir = taken && !e.ill;
    e.we    = e.wr && !e.ill && (w[11:7] != 5'd0);
    exp_q.push_back(e);
  endtask

  task automatic compare_result();
    expect_t e;
    e = exp_q.pop_front();
    check_idx("rd", e.insn[11:7], rd);
    check_bit("rd_we", e.we, rd_we);
    check_bit("redirect", e.redir, redirect);
    check_bit("illegal", e.ill, illegal);
    if (e.wr && !e.ill)
      check_word("rd_data", e.data, rd_data);
    if (e.redir)
      check_word("redirect_pc", e.tgt, redirect_pc);
  endtask

  task automatic drive_insn(input word_t w, input word_t p, input word_t a, input word_t b);
    in_valid <= 1'b1;
    insn     <= insn_word_u'(w);
    pc       <= p;
    rs1_data <= a;
    rs2_data <= b;
  endtask

  // sample on the falling edge, gives up after 20 cycles
  task automatic wait_result(output int cycles);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!res_valid && cycles < 20);
  endtask

  task automatic run_one(input word_t w, input word_t p, input word_t a, input word_t b);
    int lat;
    predict(w, p, a, b);
    @(posedge clk);
    drive_insn(w, p, a, b);
    @(posedge clk);
    in_valid <= 1'b0;
    wait_result(lat);
    if (!res_valid) begin
      timeout_errors++;
      exp_q.delete();
      $display("timeout: no result for instruction %h after %0d cycles", w, lat);
    end else begin
      if (lat != 2) begin
        check_errors++;
        $display("result for instruction %h came after %0d cycles, not 2", w, lat);
      end
      compare_result();
    end
  endtask

  task automatic test_reset();
    int n;
    n = 0;
    while (rst !== 1'b0 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (rst !== 1'b0) begin
      timeout_errors++;
      $display("timeout: rst still asserted after %0d cycles", n);
    end
    repeat (3) begin
      @(negedge clk);
      check_bit("res_valid", 1'b0, res_valid);
      check_bit("rd_we", 1'b0, rd_we);
      check_bit("redirect", 1'b0, redirect);
      check_bit("illegal", 1'b0, illegal);
    end
  endtask

  task automatic test_arith();
    logic [2:0]  f3;
    logic [11:0] imm;
    reg_idx_t    r;
    for (int k = 0; k < 8; k++) begin
      f3  = 3'(k);
      r   = reg_idx_t'(1 + ($urandom() % 31));
      imm = 12'($urandom());
      if (f3 == f3_sll || f3 == f3_srl)
        imm = {7'h00, imm[4:0]};
      run_one(enc_r(f7_base, 5'd3, 5'd4, f3, r, opc_op), 32'h100, $urandom(), $urandom());
      run_one(enc_i(imm, 5'd4, f3, r, opc_op_imm), 32'h100, $urandom(), $urandom());
    end
    // sub, sra and srai
    run_one(enc_r(f7_alt, 5'd3, 5'd4, f3_add, 5'd6, opc_op), 32'h100, $urandom(), $urandom());
    run_one(enc_r(f7_alt, 5'd3, 5'd4, f3_srl, 5'd6, opc_op), 32'h100,
            32'h8000_0000 | $urandom(), $urandom());
    run_one(enc_i({f7_alt, 5'd9}, 5'd4, f3_srl, 5'd6, opc_op_imm), 32'h100,
            32'hf000_1234, 32'd0);
    // signed and unsigned compares disagree here
    run_one(enc_r(f7_base, 5'd3, 5'd4, f3_slt, 5'd5, opc_op), 32'h100, 32'hffff_fff0, 32'd1);
    run_one(enc_r(f7_base, 5'd3, 5'd4, f3_sltu, 5'd5, opc_op), 32'h100, 32'hffff_fff0, 32'd1);
  endtask

  task automatic test_upper_jump();
    run_one({20'habcde, 5'd5, opc_lui}, 32'h0000_1000, 32'd0, 32'd0);
    run_one({20'h12345, 5'd6, opc_auipc}, 32'h0000_1000, 32'd0, 32'd0);
    run_one(enc_j(21'h000800, 5'd1), 32'h0000_2000, 32'd0, 32'd0);
    run_one(enc_j(21'h1ffff0, 5'd1), 32'h0000_2000, 32'd0, 32'd0);
    run_one(enc_i(12'hff5, 5'd2, 3'd0, 5'd1, opc_jalr), 32'h0000_2000, 32'h3001, 32'd0);
    run_one(enc_i(12'h007, 5'd2, 3'd0, 5'd1, opc_jalr), 32'h0000_2000, 32'h4000, 32'd0);
  endtask

  task automatic test_branches();
    logic [2:0] codes[$] = '{f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};
    foreach (codes[i]) begin
      run_one(enc_b(13'h0040, codes[i]), 32'h8000, 32'd5, 32'd5);
      run_one(enc_b(13'h1ff0, codes[i]), 32'h8000, 32'd5, 32'd9);
      run_one(enc_b(13'h00c0, codes[i]), 32'h8000, 32'hffff_fff0, 32'd3);
    end
  endtask

  task automatic test_x0_illegal();
    run_one(enc_r(f7_base, 5'd3, 5'd4, f3_add, 5'd0, opc_op), 32'h100, 32'd7, 32'd9);
    run_one(enc_j(21'h000010, 5'd0), 32'h100, 32'd0, 32'd0);
    // lw is outside this unit
    run_one(32'h0000_2083, 32'h100, 32'd0, 32'd0);
    run_one(enc_r(7'h01, 5'd3, 5'd4, f3_add, 5'd5, opc_op), 32'h100, 32'd6, 32'd7);
    run_one(enc_b(13'h0020, 3'd2), 32'h100, 32'd1, 32'd1);
  endtask

  task automatic test_back_to_back();
    word_t w[$];
    word_t p[$];
    word_t a[$];
    word_t b[$];
    int    lat;
    w = '{enc_r(f7_base, 5'd3, 5'd4, f3_add, 5'd7, opc_op), {20'h80001, 5'd8, opc_lui},
          enc_b(13'h0010, f3_beq), enc_j(21'h1ffff8, 5'd1),
          enc_r(f7_alt, 5'd3, 5'd4, f3_srl, 5'd9, opc_op),
          enc_i(12'h800, 5'd4, f3_sltu, 5'd10, opc_op_imm)};
    p = '{32'h100, 32'h104, 32'h108, 32'h10c, 32'h110, 32'h114};
    a = '{$urandom(), 32'd0, 32'h55, 32'd0, 32'h8000_0000 | $urandom(), $urandom()};
    b = '{$urandom(), 32'd0, 32'h55, 32'd0, $urandom(), 32'd0};
    foreach (w[i])
      predict(w[i], p[i], a[i], b[i]);
    fork
      begin
        foreach (w[i]) begin
          @(posedge clk);
          drive_insn(w[i], p[i], a[i], b[i]);
        end
        @(posedge clk);
        in_valid <= 1'b0;
      end
      begin
        wait_result(lat);
        if (!res_valid) begin
          timeout_errors++;
          exp_q.delete();
          $display("timeout: back-to-back stream gave no result in %0d cycles", lat);
        end else begin
          foreach (w[i]) begin
            if (!res_valid) begin
              check_errors++;
              $display("result %0d of the back-to-back stream missing at %0t", i, $time);
            end
            compare_result();
            @(negedge clk);
          end
        end
      end
    join
  endtask

  initial begin
    check_errors   = 0;
    timeout_errors = 0;
    in_valid <= 1'b0;
    insn     <= '0;
    pc       <= '0;
    rs1_data <= '0;
    rs2_data <= '0;
    void'($urandom(32'hf2a7));
    test_reset();
    test_arith();
    test_upper_jump();
    test_branches();
    test_x0_illegal();
    test_back_to_back();
    $display("errors: %0d failed checks, %0d timeouts", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: files.f
logic/rv_exec_pkg.sv
logic/int_alu.sv
logic/branch_unit.sv
logic/commit_stage.sv
logic/exec_stage.sv
testbench/clock_gen.sv
testbench/exec_stage_props.sv
testbench/tb_exec_stage.sv

// File: run_sim.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_exec_stage -f files.f \
  && ./obj_dir/Vtb_exec_stage > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0
